// File: rtl/conv_pkg.sv
package conv_pkg;

	localparam int MEM_ADDR_W = 16;
	localparam int MEM_DATA_W = 32;
	localparam int DIM_W      = 8;
	localparam int FIFO_DEPTH = 4;
	localparam int NUM_REQ    = 3;	// 0 loader, 1 controller, 2 writer
	localparam int DESC_WORDS = 7;
	localparam int ACC_W      = 20;	// nine 17 bit products

	typedef logic [MEM_ADDR_W-1:0] mem_addr_t;
	typedef logic [MEM_DATA_W-1:0] mem_word_t;

	typedef logic [7:0]         pixel_t;
	typedef logic signed [7:0]  coeff_t;
	typedef logic signed [15:0] result_t;

	// pixel and its first-of-row mark travel together through the pixel FIFO
	typedef struct packed {
		logic   row_start;
		pixel_t pixel;
	} pix_beat_t;

	localparam mem_addr_t START_ADDR = 16'h0100;	// descriptor follows

endpackage

// File: rtl/stream_fifo.sv
`timescale 1ns/1ps

module stream_fifo import conv_pkg::*; #(
	parameter type payload_t = pixel_t
) (
	input  logic     clk,
	input  logic     rst_n,
	input  logic     in_valid,
	output logic     in_ready,
	input  payload_t in_data,
	output logic     out_valid,
	input  logic     out_ready,
	output payload_t out_data
);

	payload_t buf_mem [FIFO_DEPTH];
	logic [$clog2(FIFO_DEPTH)-1:0] wr_ptr, rd_ptr;
	logic [$clog2(FIFO_DEPTH+1)-1:0] count;
	logic push, pop;

	assign in_ready  = count != FIFO_DEPTH;
	assign out_valid = count != 0;
	assign out_data  = buf_mem[rd_ptr];
	assign push      = in_valid && in_ready;
	assign pop       = out_valid && out_ready;

	always_ff @(posedge clk) begin
		if (push)
			buf_mem[wr_ptr] <= in_data;
	end

	always_ff @(posedge clk, negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push)
				wr_ptr <= (wr_ptr == FIFO_DEPTH - 1) ? '0 : wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= (rd_ptr == FIFO_DEPTH - 1) ? '0 : rd_ptr + 1'b1;
			if (push && !pop)
				count <= count + 1'b1;
			else if (pop && !push)
				count <= count - 1'b1;
		end
	end

endmodule

// File: rtl/mem_arbiter.sv
`timescale 1ns/1ps

module mem_arbiter import conv_pkg::*; (
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic [NUM_REQ-1:0]        req_valid,
	output logic [NUM_REQ-1:0]        req_ready,
	input  logic [NUM_REQ-1:0]        req_we,
	input  mem_addr_t [NUM_REQ-1:0]   req_addr,
	input  mem_word_t [NUM_REQ-1:0]   req_wdata,
	output logic [NUM_REQ-1:0]        rsp_valid,
	output mem_word_t [NUM_REQ-1:0]   rsp_data,
	output logic                      mem_valid,
	input  logic                      mem_ready,
	output logic                      mem_we,
	output mem_addr_t                 mem_addr,
	output mem_word_t                 mem_wdata,
	input  logic                      mem_rvalid,
	input  mem_word_t                 mem_rdata
);

	logic [NUM_REQ-1:0] pick, grant, lock_grant;
	logic [$clog2(NUM_REQ)-1:0] last_idx, grant_idx;
	logic locked, rsp_wait;

	// nearest valid requester after the last one served wins
	always_comb begin : rr_pick
		int idx;
		pick = '0;
		for (int i = NUM_REQ; i >= 1; i--) begin
			idx = int'(last_idx) + i;
			if (idx >= NUM_REQ)
				idx -= NUM_REQ;
			if (req_valid[idx]) begin
				pick      = '0;
				pick[idx] = 1'b1;
			end
		end
	end

	assign grant = locked ? lock_grant : pick;

	always_comb begin
		grant_idx = '0;
		for (int i = 0; i < NUM_REQ; i++)
			if (grant[i])
				grant_idx = i[$clog2(NUM_REQ)-1:0];
	end

	assign mem_valid = |(req_valid & grant) && !rsp_wait;
	assign mem_we    = req_we[grant_idx];
	assign mem_addr  = req_addr[grant_idx];
	assign mem_wdata = req_wdata[grant_idx];
	assign req_ready = grant & {NUM_REQ{mem_ready && !rsp_wait}};
	assign rsp_valid = lock_grant & {NUM_REQ{mem_rvalid && rsp_wait}};
	assign rsp_data  = {NUM_REQ{mem_rdata}};	// qualified by rsp_valid

	always_ff @(posedge clk, negedge rst_n) begin
		if (!rst_n) begin
			locked     <= 1'b0;
			lock_grant <= '0;
			rsp_wait   <= 1'b0;
			last_idx   <= '0;
		end else if (rsp_wait) begin
			if (mem_rvalid) begin
				rsp_wait <= 1'b0;
				locked   <= 1'b0;
			end
		end else if (mem_valid) begin
			lock_grant <= grant;
			if (mem_ready) begin
				last_idx <= grant_idx;
				locked   <= !mem_we;	// reads keep the grant for the response
				rsp_wait <= !mem_we;
			end else begin
				locked <= 1'b1;
			end
		end
	end

endmodule

// File: rtl/config_loader.sv
`timescale 1ns/1ps

module config_loader import conv_pkg::*; (
	input  logic             clk,
	input  logic             rst_n,
	output logic             req_valid,
	input  logic             req_ready,
	output logic             req_we,
	output mem_addr_t        req_addr,
	output mem_word_t        req_wdata,
	input  logic             rsp_valid,
	input  mem_word_t        rsp_data,
	input  logic             done,
	output logic             job_start,
	output logic [DIM_W-1:0] width,
	output logic [DIM_W-1:0] height,
	output mem_addr_t        src_base,
	output mem_addr_t        dst_base,
	output coeff_t [8:0]     coeff
);

	typedef enum logic [1:0] {POLL, CLEAR, FETCH, BUSY} state_t;

	state_t state;
	logic rd_pending;
	logic [2:0] word_idx;

	always_ff @(posedge clk, negedge rst_n) begin
		if (!rst_n) begin
			state      <= POLL;
			req_valid  <= 1'b0;
			req_we     <= 1'b0;
			req_addr   <= '0;
			req_wdata  <= '0;
			rd_pending <= 1'b0;
			word_idx   <= '0;
			job_start  <= 1'b0;
		end else begin
			job_start <= 1'b0;
			if (req_valid && req_ready) begin
				req_valid  <= 1'b0;
				rd_pending <= !req_we;
			end
			if (rsp_valid)
				rd_pending <= 1'b0;
			case (state)
				POLL: begin
					if (rsp_valid && rsp_data == mem_word_t'(1)) begin
						state     <= CLEAR;	// claim the job
						req_valid <= 1'b1;
						req_we    <= 1'b1;
						req_addr  <= START_ADDR;
						req_wdata <= '0;
					end else if (!req_valid && !rd_pending) begin
						req_valid <= 1'b1;
						req_we    <= 1'b0;
						req_addr  <= START_ADDR;
					end
				end
				CLEAR: begin
					if (req_valid && req_ready) begin
						state     <= FETCH;
						req_valid <= 1'b1;
						req_we    <= 1'b0;
						req_addr  <= START_ADDR + 1'b1;
						word_idx  <= '0;
					end
				end
				FETCH: begin
					if (rsp_valid) begin
						if (word_idx == DESC_WORDS - 1) begin
							state     <= BUSY;
							job_start <= 1'b1;
						end else begin
							word_idx  <= word_idx + 1'b1;
							req_valid <= 1'b1;
							req_addr  <= req_addr + 1'b1;
						end
					end
				end
				BUSY: if (done) state <= POLL;
				default: state <= POLL;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == FETCH && rsp_valid) begin
			case (word_idx)
				3'd0: width    <= rsp_data[DIM_W-1:0];
				3'd1: height   <= rsp_data[DIM_W-1:0];
				3'd2: src_base <= rsp_data[MEM_ADDR_W-1:0];
				3'd3: dst_base <= rsp_data[MEM_ADDR_W-1:0];
				3'd4: for (int b = 0; b < 4; b++) coeff[b] <= rsp_data[8*b +: 8];
				3'd5: for (int b = 0; b < 4; b++) coeff[4+b] <= rsp_data[8*b +: 8];
				3'd6: coeff[8] <= rsp_data[7:0];
				default: ;
			endcase
		end
	end

endmodule

// File: rtl/conv_controller.sv
`timescale 1ns/1ps

module conv_controller import conv_pkg::*; (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             job_start,
	input  logic [DIM_W-1:0] width,
	input  logic [DIM_W-1:0] height,
	input  mem_addr_t        src_base,
	output logic             req_valid,
	input  logic             req_ready,
	output logic             req_we,
	output mem_addr_t        req_addr,
	output mem_word_t        req_wdata,
	input  logic             rsp_valid,
	input  mem_word_t        rsp_data,
	output logic             pix_valid,
	input  logic             pix_ready,
	output pixel_t           pix_data,
	output logic             row_start
);

	typedef enum logic {IDLE, SWEEP} state_t;

	state_t state;
	logic [DIM_W-1:0] out_row;
	logic [DIM_W:0] col;	// padded column, up to width+1
	logic [1:0] tap;
	mem_addr_t row_addr, stride, tap_off;
	logic rd_pending, all_issued, first_rd, last_rd;
	logic col_end, last_tap, issue;

	assign stride   = mem_addr_t'(width) + 2'd2;
	assign tap_off  = (tap == 2'd0) ? '0 : (tap == 2'd1) ? stride : stride << 1;
	assign col_end  = col == {1'b0, width} + 1'b1;
	assign last_tap = col_end && tap == 2'd2 && out_row == height - 1'b1;

	// a free FIFO slot now stays free until the single response lands
	assign issue = state == SWEEP && !req_valid && !rd_pending && !all_issued && pix_ready;

	assign req_we    = 1'b0;
	assign req_wdata = '0;
	assign pix_valid = rsp_valid;
	assign pix_data  = rsp_data[7:0];
	assign row_start = rsp_valid && first_rd;

	always_ff @(posedge clk, negedge rst_n) begin
		if (!rst_n) begin
			state      <= IDLE;
			req_valid  <= 1'b0;
			req_addr   <= '0;
			rd_pending <= 1'b0;
			all_issued <= 1'b0;
			first_rd   <= 1'b0;
			last_rd    <= 1'b0;
			out_row    <= '0;
			col        <= '0;
			tap        <= '0;
			row_addr   <= '0;
		end else begin
			if (req_valid && req_ready) begin
				req_valid  <= 1'b0;
				rd_pending <= 1'b1;
			end
			case (state)
				IDLE: begin
					if (job_start) begin
						state      <= SWEEP;
						out_row    <= '0;
						col        <= '0;
						tap        <= '0;
						row_addr   <= src_base;
						all_issued <= 1'b0;
					end
				end
				SWEEP: begin
					if (issue) begin
						req_valid  <= 1'b1;
						req_addr   <= row_addr + tap_off + mem_addr_t'(col);
						first_rd   <= (col == '0) && (tap == 2'd0);
						last_rd    <= last_tap;
						all_issued <= last_tap;
						if (tap == 2'd2) begin
							tap <= '0;
							if (col_end) begin
								col      <= '0;
								out_row  <= out_row + 1'b1;
								row_addr <= row_addr + stride;
							end else begin
								col <= col + 1'b1;
							end
						end else begin
							tap <= tap + 1'b1;
						end
					end
					if (rsp_valid) begin
						rd_pending <= 1'b0;
						if (last_rd)
							state <= IDLE;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

endmodule

// File: rtl/conv_datapath.sv
`timescale 1ns/1ps

module conv_datapath import conv_pkg::*; (
	input  logic         clk,
	input  logic         rst_n,
	input  coeff_t [8:0] coeff,
	input  logic         row_start,
	input  logic         pix_valid,
	output logic         pix_ready,
	input  pixel_t       pix_data,
	output logic         res_valid,
	input  logic         res_ready,
	output result_t      res_data
);

	pixel_t win [3][3];	// [row][col], col 0 oldest
	pixel_t nxt [3][3];
	pixel_t col_buf [2];
	logic [1:0] tap_cnt, col_cnt;
	logic signed [ACC_W-1:0] acc;
	result_t sat;
	logic take, col_done;

	assign pix_ready = !res_valid || res_ready;
	assign take      = pix_valid && pix_ready;
	assign col_done  = take && tap_cnt == 2'd2;

	// window as it looks once the incoming column shifts in
	always_comb begin
		for (int r = 0; r < 3; r++) begin
			nxt[r][0] = win[r][1];
			nxt[r][1] = win[r][2];
		end
		nxt[0][2] = col_buf[0];
		nxt[1][2] = col_buf[1];
		nxt[2][2] = pix_data;
	end

	always_comb begin
		acc = '0;
		for (int k = 0; k < 9; k++)
			acc += $signed(coeff[k]) * $signed({1'b0, nxt[k / 3][k % 3]});
		if (acc > 32767)
			sat = 16'sh7fff;
		else if (acc < -32768)
			sat = 16'sh8000;
		else
			sat = acc[15:0];
	end

	always_ff @(posedge clk, negedge rst_n) begin
		if (!rst_n) begin
			tap_cnt   <= '0;
			col_cnt   <= '0;
			res_valid <= 1'b0;
		end else begin
			if (res_valid && res_ready)
				res_valid <= 1'b0;
			if (take) begin
				tap_cnt <= (tap_cnt == 2'd2) ? 2'd0 : tap_cnt + 1'b1;
				if (row_start)
					col_cnt <= '0;
			end
			if (col_done) begin
				if (col_cnt == 2'd2)
					res_valid <= 1'b1;	// window full for this row
				else
					col_cnt <= col_cnt + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (take && tap_cnt != 2'd2)
			col_buf[tap_cnt[0]] <= pix_data;
		if (col_done) begin
			win      <= nxt;
			res_data <= sat;
		end
	end

endmodule

// File: rtl/result_writer.sv
`timescale 1ns/1ps

module result_writer import conv_pkg::*; (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             job_start,
	input  logic [DIM_W-1:0] width,
	input  logic [DIM_W-1:0] height,
	input  mem_addr_t        dst_base,
	input  logic             res_valid,
	output logic             res_ready,
	input  result_t          res_data,
	output logic             req_valid,
	input  logic             req_ready,
	output logic             req_we,
	output mem_addr_t        req_addr,
	output mem_word_t        req_wdata,
	output logic             done
);

	logic [2*DIM_W-1:0] count, total;

	assign total     = width * height;
	assign res_ready = !req_valid;	// one write held at a time
	assign req_we    = 1'b1;

	always_ff @(posedge clk, negedge rst_n) begin
		if (!rst_n) begin
			req_valid <= 1'b0;
			req_addr  <= '0;
			req_wdata <= '0;
			count     <= '0;
			done      <= 1'b0;
		end else begin
			done <= 1'b0;
			if (job_start)
				count <= '0;
			if (res_valid && res_ready) begin
				req_valid <= 1'b1;
				req_addr  <= dst_base + mem_addr_t'(count);
				req_wdata <= mem_word_t'(res_data);	// sign extended
			end
			if (req_valid && req_ready) begin
				req_valid <= 1'b0;
				count     <= count + 1'b1;
				if (count + 1'b1 == total)
					done <= 1'b1;
			end
		end
	end

endmodule

// File: rtl/conv_engine_top.sv
`timescale 1ns/1ps

module conv_engine_top import conv_pkg::*; (
	input  logic      clk,
	input  logic      rst_n,
	output logic      mem_valid,
	input  logic      mem_ready,
	output logic      mem_we,
	output mem_addr_t mem_addr,
	output mem_word_t mem_wdata,
	input  logic      mem_rvalid,
	input  mem_word_t mem_rdata,
	output logic      done
);

	logic [NUM_REQ-1:0] req_valid, req_ready, req_we, rsp_valid;
	mem_addr_t [NUM_REQ-1:0] req_addr;
	mem_word_t [NUM_REQ-1:0] req_wdata, rsp_data;

	logic job_start;
	logic [DIM_W-1:0] width, height;
	mem_addr_t src_base, dst_base;
	coeff_t [8:0] coeff;

	logic ctl_pix_valid, ctl_pix_ready, ctl_row_start;
	pixel_t ctl_pix_data;
	pix_beat_t pix_in, pix_out;
	logic dp_pix_valid, dp_pix_ready;
	logic dp_res_valid, dp_res_ready, wr_res_valid, wr_res_ready;
	result_t dp_res_data, wr_res_data;

	assign pix_in.row_start = ctl_row_start;
	assign pix_in.pixel     = ctl_pix_data;

	config_loader u_loader (
		.clk, .rst_n,
		.req_valid(req_valid[0]), .req_ready(req_ready[0]), .req_we(req_we[0]),
		.req_addr(req_addr[0]), .req_wdata(req_wdata[0]),
		.rsp_valid(rsp_valid[0]), .rsp_data(rsp_data[0]),
		.done, .job_start, .width, .height, .src_base, .dst_base, .coeff
	);

	conv_controller u_ctrl (
		.clk, .rst_n, .job_start, .width, .height, .src_base,
		.req_valid(req_valid[1]), .req_ready(req_ready[1]), .req_we(req_we[1]),
		.req_addr(req_addr[1]), .req_wdata(req_wdata[1]),
		.rsp_valid(rsp_valid[1]), .rsp_data(rsp_data[1]),
		.pix_valid(ctl_pix_valid), .pix_ready(ctl_pix_ready), .pix_data(ctl_pix_data),
		.row_start(ctl_row_start)
	);

	stream_fifo #(.payload_t(pix_beat_t)) u_pix_fifo (
		.clk, .rst_n,
		.in_valid(ctl_pix_valid), .in_ready(ctl_pix_ready), .in_data(pix_in),
		.out_valid(dp_pix_valid), .out_ready(dp_pix_ready), .out_data(pix_out)
	);

	conv_datapath u_dp (
		.clk, .rst_n, .coeff, .row_start(pix_out.row_start),
		.pix_valid(dp_pix_valid), .pix_ready(dp_pix_ready), .pix_data(pix_out.pixel),
		.res_valid(dp_res_valid), .res_ready(dp_res_ready), .res_data(dp_res_data)
	);

	stream_fifo #(.payload_t(result_t)) u_res_fifo (
		.clk, .rst_n,
		.in_valid(dp_res_valid), .in_ready(dp_res_ready), .in_data(dp_res_data),
		.out_valid(wr_res_valid), .out_ready(wr_res_ready), .out_data(wr_res_data)
	);

	result_writer u_writer (
		.clk, .rst_n, .job_start, .width, .height, .dst_base,
		.res_valid(wr_res_valid), .res_ready(wr_res_ready), .res_data(wr_res_data),
		.req_valid(req_valid[2]), .req_ready(req_ready[2]), .req_we(req_we[2]),
		.req_addr(req_addr[2]), .req_wdata(req_wdata[2]),
		.done
	);

	mem_arbiter u_arb (
		.clk, .rst_n,
		.req_valid, .req_ready, .req_we, .req_addr, .req_wdata, .rsp_valid, .rsp_data,
		.mem_valid, .mem_ready, .mem_we, .mem_addr, .mem_wdata, .mem_rvalid, .mem_rdata
	);

endmodule

// File: verif/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
	output logic clk,
	output logic rst_n
);

	localparam int HALF_PERIOD  = 10;	// 20 ns clock
	localparam int RESET_CYCLES = 8;

	initial begin
		clk = 1'b0;
		forever #HALF_PERIOD clk = ~clk;
	end

	initial begin
		rst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		rst_n <= 1'b1;
	end

endmodule

// File: verif/conv_engine_chk.sv
`timescale 1ns/1ps

module conv_engine_chk import conv_pkg::*; (
	input logic               clk,
	input logic               rst_n,
	input logic [NUM_REQ-1:0] grant,
	input logic [NUM_REQ-1:0] req_valid,
	input logic [NUM_REQ-1:0] req_ready,
	input logic [NUM_REQ-1:0] req_we,
	input logic [NUM_REQ-1:0] rsp_valid,
	input logic               mem_valid,
	input logic               mem_ready,
	input logic               mem_we,
	input mem_addr_t          mem_addr,
	input mem_word_t          mem_wdata,
	input logic               done
);

	int assert_fails = 0;
	logic [NUM_REQ-1:0] rd_owner;
	logic rd_open;

	// requester whose read is on its way back
	always @(posedge clk, negedge rst_n) begin
		if (!rst_n) begin
			rd_owner <= '0;
			rd_open  <= 1'b0;
		end else if (|(req_valid & req_ready & ~req_we)) begin
			rd_owner <= req_valid & req_ready & ~req_we;
			rd_open  <= 1'b1;
		end else if (|rsp_valid) begin
			rd_open <= 1'b0;
		end
	end

	grant_onehot: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(grant))
		else begin
			$error("arbiter granted more than one requester");
			assert_fails++;
		end

	req_hold: assert property (@(posedge clk) disable iff (!rst_n)
		mem_valid && !mem_ready |=>
			mem_valid && $stable(mem_we) && $stable(mem_addr) && $stable(mem_wdata))
		else begin
			$error("memory request changed or dropped before mem_ready");
			assert_fails++;
		end

	rsp_routed: assert property (@(posedge clk) disable iff (!rst_n)
		|rsp_valid |-> rd_open && rsp_valid == rd_owner)
		else begin
			$error("read response sent to a requester without an accepted read");
			assert_fails++;
		end

	done_pulse: assert property (@(posedge clk) disable iff (!rst_n) done |=> !done)
		else begin
			$error("done held high for more than one cycle");
			assert_fails++;
		end

endmodule

bind conv_engine_top conv_engine_chk u_chk (
	.clk, .rst_n, .grant(u_arb.grant),
	.req_valid, .req_ready, .req_we, .rsp_valid,
	.mem_valid, .mem_ready, .mem_we, .mem_addr, .mem_wdata, .done
);

// File: verif/conv_engine_tb.sv
`timescale 1ns/1ps

module conv_engine_tb import conv_pkg::*; ();

	// padded source sizes of every job run below
	localparam int SRC_PIXELS  = 7*6 + 9*7 + 2*(6*5) + 5*5 + 7*4 + 8*8;
	localparam int CYCLE_LIMIT = 40 * SRC_PIXELS + 500;

	logic clk, rst_n;
	logic mem_valid, mem_we, done;
	mem_addr_t mem_addr;
	mem_word_t mem_wdata;
	logic mem_ready = 1'b0;
	logic mem_rvalid = 1'b0;
	mem_word_t mem_rdata = '0;

	mem_word_t mem [0:65535];
	logic rd_busy = 1'b0;
	int rd_left = 0;
	mem_addr_t rd_addr = '0;
	int ready_pct = 85;	// percent of cycles with mem_ready high
	int cycles = 0;
	int done_total = 0;
	int jobs_done = 0;
	int test_errs = 0;
	int tests_passed = 0;
	int tests_failed = 0;
	int img [0:255];	// padded source, row major
	int coef [9];

	tb_clock_gen u_clk (.clk, .rst_n);

	conv_engine_top DUT (
		.clk, .rst_n, .mem_valid, .mem_ready, .mem_we, .mem_addr, .mem_wdata,
		.mem_rvalid, .mem_rdata, .done
	);

	// memory model with one read in flight and 1 to 3 cycles of latency
	always @(posedge clk) begin
		mem_ready  <= $urandom_range(99) < ready_pct;
		mem_rvalid <= 1'b0;
		if (rd_busy) begin
			if (rd_left == 0) begin
				mem_rvalid <= 1'b1;
				mem_rdata  <= mem[rd_addr];
				rd_busy    <= 1'b0;
			end else begin
				rd_left <= rd_left - 1;
			end
		end
		if (mem_valid && mem_ready) begin
			if (mem_we) begin
				mem[mem_addr] <= mem_wdata;
			end else begin
				rd_busy <= 1'b1;
				rd_addr <= mem_addr;
				rd_left <= $urandom_range(2);
			end
		end
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (rst_n && done)
			done_total <= done_total + 1;
		if (cycles >= CYCLE_LIMIT) begin
			$display("timeout: the engine did not finish within %0d cycles", CYCLE_LIMIT);
			$display("SIMULATION FAILED");
			$finish;
		end
	end

	task automatic fill_image(input int w, input int h, input int mode);
		int idx;
		for (int r = 0; r < h + 2; r++) begin
			for (int c = 0; c < w + 2; c++) begin
				idx = r * (w + 2) + c;
				if (r == 0 || c == 0 || r == h + 1 || c == w + 1)
					img[idx] = 0;	// zero border
				else if (mode == 0)
					img[idx] = (idx * 37 + 11) % 256;
				else if (mode == 1)
					img[idx] = $urandom_range(255);
				else
					img[idx] = 255;
			end
		end
	endtask

	// mode 0 identity, 1 random, 2 every tap set to value
	task automatic fill_coefs(input int mode, input int value);
		for (int k = 0; k < 9; k++) begin
			if (mode == 0)
				coef[k] = (k == 4) ? 1 : 0;
			else if (mode == 1)
				coef[k] = int'($urandom_range(255)) - 128;
			else
				coef[k] = value;
		end
	endtask

	function automatic int expected_pixel(input int w, input int r, input int c);
		int acc;
		acc = 0;
		for (int k = 0; k < 9; k++)
			acc += coef[k] * img[(r + k / 3) * (w + 2) + c + k % 3];
		if (acc > 32767)
			acc = 32767;
		else if (acc < -32768)
			acc = -32768;
		return acc;
	endfunction

	task automatic start_job(input int w, input int h,
		input mem_addr_t src, input mem_addr_t dst);
		for (int i = 0; i < (w + 2) * (h + 2); i++)
			mem[src + i] <= mem_word_t'(img[i]);
		for (int i = 0; i < w * h; i++)
			mem[dst + i] <= 32'h5a5a_5a5a;	// stale pattern the engine overwrites
		mem[START_ADDR + 1] <= mem_word_t'(w);
		mem[START_ADDR + 2] <= mem_word_t'(h);
		mem[START_ADDR + 3] <= mem_word_t'(src);
		mem[START_ADDR + 4] <= mem_word_t'(dst);
		mem[START_ADDR + 5] <= {8'(coef[3]), 8'(coef[2]), 8'(coef[1]), 8'(coef[0])};
		mem[START_ADDR + 6] <= {8'(coef[7]), 8'(coef[6]), 8'(coef[5]), 8'(coef[4])};
		mem[START_ADDR + 7] <= {24'h0, 8'(coef[8])};
		mem[START_ADDR]     <= 32'd1;
	endtask

	task automatic finish_job(input string name, input int w, input int h,
		input mem_addr_t dst);
		int want;
		int got;
		@(posedge clk);
		while (!done)
			@(posedge clk);
		jobs_done++;
		for (int r = 0; r < h; r++) begin
			for (int c = 0; c < w; c++) begin
				want = expected_pixel(w, r, c);
				got  = int'(mem[dst + r * w + c]);
				assert (got == want) else begin
					$display("Error: %s pixel (%0d,%0d) expected %0d actual %0d",
						name, r, c, want, got);
					test_errs++;
				end
			end
		end
		assert (mem[START_ADDR] == '0) else begin
			$display("%s: the start word was not cleared by the engine", name);
			test_errs++;
		end
		@(posedge clk);	// pulse counter is one edge behind
		assert (done_total == jobs_done) else begin
			$display("%s: done pulsed %0d times for %0d jobs", name, done_total, jobs_done);
			test_errs++;
		end
	endtask

	task automatic run_job(input string name, input int w, input int h,
		input mem_addr_t src, input mem_addr_t dst);
		start_job(w, h, src, dst);
		finish_job(name, w, h, dst);
	endtask

	task automatic end_test(input string name);
		if (test_errs == 0) begin
			tests_passed++;
			$display("test %s: ok", name);
		end else begin
			tests_failed++;
			$display("test %s: %0d errors", name, test_errs);
		end
		test_errs = 0;
	endtask

	initial begin
		void'($urandom(26));
		for (int i = 0; i < 65536; i++)
			mem[i] = {~16'(i), 16'(i)};	// distinct word per address
		mem[START_ADDR] = '0;
		@(posedge rst_n);
		@(posedge clk);

		fill_image(5, 4, 0);
		fill_coefs(0, 0);
		run_job("identity_5x4", 5, 4, 16'h1000, 16'h2000);
		end_test("identity_5x4");

		fill_image(7, 5, 1);
		fill_coefs(1, 0);
		run_job("random_7x5", 7, 5, 16'h1000, 16'h2000);
		end_test("random_7x5");

		fill_image(4, 3, 2);
		fill_coefs(2, 127);
		run_job("sat_max", 4, 3, 16'h1000, 16'h2000);
		end_test("sat_max");

		fill_coefs(2, -128);
		run_job("sat_min", 4, 3, 16'h1000, 16'h2000);
		end_test("sat_min");

		fill_image(3, 3, 1);
		fill_coefs(1, 0);
		run_job("back_to_back_a", 3, 3, 16'h3000, 16'h4000);
		fill_image(5, 2, 0);
		run_job("back_to_back_b", 5, 2, 16'h5000, 16'h6000);
		end_test("back_to_back");

		ready_pct <= 50;	// heavy back-pressure
		fill_image(6, 6, 1);
		fill_coefs(1, 0);
		run_job("stall_6x6", 6, 6, 16'h1000, 16'h2000);
		end_test("stall_6x6");

		$display("tests passed %0d, failed %0d, assertion failures %0d",
			tests_passed, tests_failed, DUT.u_chk.assert_fails);
		if (tests_failed == 0 && DUT.u_chk.assert_fails == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

endmodule

// File: conv_engine.f
rtl/conv_pkg.sv
rtl/stream_fifo.sv
rtl/mem_arbiter.sv
rtl/config_loader.sv
rtl/conv_controller.sv
rtl/conv_datapath.sv
rtl/result_writer.sv
rtl/conv_engine_top.sv
verif/tb_clock_gen.sv
verif/conv_engine_chk.sv
verif/conv_engine_tb.sv

// File: Bender.yml
package:
  name: conv_engine

sources:
  - files:
      - rtl/conv_pkg.sv
      - rtl/stream_fifo.sv
      - rtl/mem_arbiter.sv
      - rtl/config_loader.sv
      - rtl/conv_controller.sv
      - rtl/conv_datapath.sv
      - rtl/result_writer.sv
      - rtl/conv_engine_top.sv
  - target: test
    files:
      - verif/tb_clock_gen.sv
      - verif/conv_engine_chk.sv
      - verif/conv_engine_tb.sv
